//--- cmd_addr_match.sv
`timescale 1ns/1ps
`include "pwm_cmd_defines.svh"
`default_nettype none

module cmd_addr_match (
    input  wire         rst,
    input  wire         clk,
    input  wire  [7:0]  ad,
    input  wire         stb,
    output logic [1:0]  win_hit,
    output logic [15:0] frame_addr,
    output logic [7:0]  dbyte,
    output logic        dbyte_valid
);
    import pwm_cmd_pkg::*;

    localparam logic [15:0] REG_BASE = `PWM_CMD_REG_BASE;
    localparam logic [15:0] REG_MASK = `PWM_CMD_REG_MASK;
    localparam logic [15:0] CLR_ADDR = `PWM_CMD_CLR_ADDR;
    localparam logic [15:0] CLR_MASK = `PWM_CMD_CLR_MASK;
    localparam logic [2:0]  LAST_POS = 3'(`PWM_CMD_FRAME_BYTES - 1);

    logic [2:0]  pos;           // 0 = idle, 1..5 = byte index
    logic        frame_start;
    logic [1:0]  lo_now;        // low byte match on ad
    logic [1:0]  hi_now;        // high byte match on ad
    logic [1:0]  lo_match;
    logic [7:0]  lo_byte;
    logic [1:0]  hit_pend;
    logic [15:0] addr_pend;
    logic        frame_hit;     // current frame hit some window
    logic [7:0]  data_d1;
    logic        data_d1_valid;

    function automatic logic byte_match(input logic [7:0] b, input logic [7:0] ref_val,
                                        input logic [7:0] mask);
        return ((b ^ ref_val) & mask) == 8'h00;
    endfunction

    assign frame_start = stb && (pos == 3'd0); // strobes mid-frame dropped

    always_comb begin
        lo_now[WIN_REG] = byte_match(ad, REG_BASE[7:0], REG_MASK[7:0]);
        lo_now[WIN_CLR] = byte_match(ad, CLR_ADDR[7:0], CLR_MASK[7:0]);
        hi_now[WIN_REG] = byte_match(ad, REG_BASE[15:8], REG_MASK[15:8]);
        hi_now[WIN_CLR] = byte_match(ad, CLR_ADDR[15:8], CLR_MASK[15:8]);
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            pos <= '0;
        end else if (frame_start) begin
            pos <= 3'd1;
        end else if (pos == LAST_POS) begin
            pos <= '0;
        end else if (pos != 3'd0) begin
            pos <= pos + 3'd1;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            lo_match      <= '0;
            hit_pend      <= '0;
            win_hit       <= '0;
            frame_hit     <= 1'b0;
            data_d1_valid <= 1'b0;
            dbyte_valid   <= 1'b0;
        end else begin
            if (frame_start) begin
                lo_match <= lo_now;
            end
            hit_pend <= (pos == 3'd1) ? (lo_match & hi_now) : 2'b00;
            win_hit  <= hit_pend;          // one cycle pulse
            if (pos == 3'd2) begin
                frame_hit <= |hit_pend;
            end
            data_d1_valid <= (pos >= 3'd2);
            dbyte_valid   <= data_d1_valid && frame_hit;
        end
    end

    // address and data path
    always_ff @(posedge rst) begin
        if (frame_start) begin
            lo_byte <= ad;
        end
        if (pos == 3'd1) begin
            addr_pend <= {ad, lo_byte};
        end
        if (hit_pend != 2'b00) begin
            frame_addr <= addr_pend;       // held until next hit
        end
        data_d1 <= ad;
        dbyte   <= data_d1;
    end

endmodule

`default_nettype wire

//--- cmd_word_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_word_assemble #(
    parameter int DATA_WIDTH = 32  // multiple of 8, at most 32
) (
    input  wire                   rst,
    input  wire                   clk,
    input  wire  [1:0]            win_hit,
    input  wire  [15:0]           frame_addr,
    input  wire  [7:0]            dbyte,
    input  wire                   dbyte_valid,
    output logic [15:0]           cmd_addr,
    output logic [DATA_WIDTH-1:0] cmd_data,
    output logic [1:0]            cmd_we
);
    localparam int         NUM_BYTES = DATA_WIDTH / 8;
    localparam logic [2:0] LAST_BYTE = 3'(NUM_BYTES - 1);

    logic [1:0]            win_r;
    logic [15:0]           addr_r;
    logic [DATA_WIDTH-1:0] shreg;
    logic [DATA_WIDTH+7:0] shift_cat;
    logic [DATA_WIDTH-1:0] word_next;
    logic [2:0]            byte_cnt;
    logic                  word_done;

    // new byte enters at the top, first byte ends up lowest
    assign shift_cat = {dbyte, shreg};
    assign word_next = shift_cat[DATA_WIDTH+7:8];
    assign word_done = dbyte_valid && (byte_cnt == LAST_BYTE);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            win_r    <= '0;
            byte_cnt <= '0;
            cmd_we   <= '0;
            cmd_addr <= '0;
            cmd_data <= '0;
        end else begin
            if (|win_hit) begin
                win_r    <= win_hit;
                byte_cnt <= '0;
            end else if (word_done) begin
                byte_cnt <= '0;
            end else if (dbyte_valid) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
            cmd_we <= word_done ? win_r : 2'b00; // strobe for latched window
            if (word_done) begin
                cmd_addr <= addr_r;
                cmd_data <= word_next;
            end
        end
    end

    always_ff @(posedge rst) begin
        if (|win_hit) begin
            addr_r <= frame_addr;
        end
        if (dbyte_valid) begin
            shreg <= word_next;
        end
    end

endmodule

`default_nettype wire

//--- pwm_cmd.f
+incdir+.
pwm_cmd_pkg.sv
cmd_addr_match.sv
cmd_word_assemble.sv
pwm_regs.sv
pwm_core.sv
pwm_cmd_top.sv
tb_pwm_cmd_top.sv

//--- pwm_cmd_defines.svh
`ifndef PWM_CMD_DEFINES_SVH
`define PWM_CMD_DEFINES_SVH

// command frame: addr lo, addr hi, data 0..3
`define PWM_CMD_FRAME_BYTES 6

// register window, eight offsets
`define PWM_CMD_REG_BASE 16'h0840
`define PWM_CMD_REG_MASK 16'hfff8

// clear command, single address
`define PWM_CMD_CLR_ADDR 16'h08ff
`define PWM_CMD_CLR_MASK 16'hffff

// register offsets inside the window
`define PWM_OFS_CTRL   3'd0
`define PWM_OFS_PERIOD 3'd1
`define PWM_OFS_CMP    3'd2

// offsets 3 to 7 decode to nothing

`endif

//--- pwm_cmd_pkg.sv
`default_nettype none

package pwm_cmd_pkg;

    // control register fields
    typedef struct packed {
        logic [15:0] rsvd_hi;  // 31:16
        logic [7:0]  prescale; // 15:8, prescaler terminal count
        logic [5:0]  rsvd_lo;  // 7:2
        logic        invert;   // output polarity
        logic        enable;   // run counters
    } pwm_ctrl_t;

    // same word seen raw by the bus side, by field by the core
    typedef union packed {
        logic [31:0] raw;
        pwm_ctrl_t   f;
    } pwm_ctrl_u;

    // bit positions in the hit and write enable buses
    typedef enum logic [0:0] {
        WIN_REG = 1'b0,
        WIN_CLR = 1'b1
    } win_sel_e;

endpackage

`default_nettype wire

//--- pwm_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_cmd_top (
    input  wire        rst,
    input  wire        clk,
    input  wire [7:0]  ad,
    input  wire        stb,
    output wire [15:0] cmd_addr,
    output wire [31:0] cmd_data,
    output wire [1:0]  cmd_we,
    output wire        pwm_out,
    output wire        pwm_wrap
);
    import pwm_cmd_pkg::*;

    wire [1:0]      win_hit;
    wire [15:0]     frame_addr;
    wire [7:0]      dbyte;
    wire            dbyte_valid;
    wire pwm_ctrl_u ctrl;
    wire [15:0]     period;
    wire [15:0]     compare;

    cmd_addr_match u_cmd_addr_match (
        .rst         (rst),
        .clk         (clk),
        .ad          (ad),
        .stb         (stb),
        .win_hit     (win_hit),
        .frame_addr  (frame_addr),
        .dbyte       (dbyte),
        .dbyte_valid (dbyte_valid)
    );

    cmd_word_assemble #(
        .DATA_WIDTH (32)
    ) u_cmd_word_assemble (
        .rst         (rst),
        .clk         (clk),
        .win_hit     (win_hit),
        .frame_addr  (frame_addr),
        .dbyte       (dbyte),
        .dbyte_valid (dbyte_valid),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_we      (cmd_we)
    );

    pwm_regs u_pwm_regs (
        .rst      (rst),
        .clk      (clk),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we),
        .ctrl     (ctrl),
        .period   (period),
        .compare  (compare)
    );

    pwm_core u_pwm_core (
        .rst      (rst),
        .clk      (clk),
        .ctrl     (ctrl),
        .period   (period),
        .compare  (compare),
        .pwm_out  (pwm_out),
        .pwm_wrap (pwm_wrap)
    );

endmodule

`default_nettype wire

//--- pwm_core.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_core (
    input  wire                    rst,
    input  wire                    clk,
    input  wire pwm_cmd_pkg::pwm_ctrl_u ctrl,
    input  wire  [15:0]            period,
    input  wire  [15:0]            compare,
    output logic                   pwm_out,
    output logic                   pwm_wrap
);
    import pwm_cmd_pkg::*;

    pwm_ctrl_t   cfg;
    logic [7:0]  presc_cnt;
    logic [15:0] period_cnt;
    logic        presc_wrap;
    logic        period_end;

    assign cfg = ctrl.f;

    // >= so a shrinking limit cannot strand a counter above it
    assign presc_wrap = (presc_cnt >= cfg.prescale);
    assign period_end = (period_cnt >= period);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            presc_cnt  <= '0;
            period_cnt <= '0;
            pwm_wrap   <= 1'b0;
            pwm_out    <= 1'b0;
        end else if (!cfg.enable) begin
            presc_cnt  <= '0;          // parked while disabled
            period_cnt <= '0;
            pwm_wrap   <= 1'b0;
            pwm_out    <= cfg.invert;
        end else begin
            pwm_out  <= cfg.invert ^ (period_cnt < compare);
            pwm_wrap <= 1'b0;
            if (presc_wrap) begin
                presc_cnt <= '0;
                if (period_end) begin
                    period_cnt <= '0;
                    pwm_wrap   <= 1'b1; // start of a new period
                end else begin
                    period_cnt <= period_cnt + 16'd1;
                end
            end else begin
                presc_cnt <= presc_cnt + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- pwm_regs.sv
`timescale 1ns/1ps
`include "pwm_cmd_defines.svh"
`default_nettype none

module pwm_regs (
    input  wire                    rst,
    input  wire                    clk,
    input  wire  [15:0]            cmd_addr,
    input  wire  [31:0]            cmd_data,
    input  wire  [1:0]             cmd_we,
    output pwm_cmd_pkg::pwm_ctrl_u ctrl,
    output logic [15:0]            period,
    output logic [15:0]            compare
);
    import pwm_cmd_pkg::*;

    logic [2:0] reg_ofs;
    logic       reg_we;
    logic       clr_we;

    // window already qualified upstream, only offset bits matter here
    assign reg_ofs = cmd_addr[2:0];
    assign reg_we  = cmd_we[WIN_REG];
    assign clr_we  = cmd_we[WIN_CLR];

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            ctrl.raw <= '0;
            period   <= '0;
            compare  <= '0;
        end else if (clr_we) begin
            ctrl.raw <= '0;       // clear command wins
            period   <= '0;
            compare  <= '0;
        end else if (reg_we) begin
            case (reg_ofs)
                `PWM_OFS_CTRL: begin
                    ctrl.raw <= cmd_data;
                end
                `PWM_OFS_PERIOD: begin
                    period <= cmd_data[15:0];
                end
                `PWM_OFS_CMP: begin
                    compare <= cmd_data[15:0];
                end
                default: begin
                    // unused offset, write dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps -f pwm_cmd.f \
    --top-module tb_pwm_cmd_top -o sim_pwm_cmd > build.log 2>&1 \
    || { cat build.log; echo "verilator build error"; exit 1; }

./obj_dir/sim_pwm_cmd > sim.log 2>&1 \
    || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

grep -q "sim failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "RESULT: no result in log"; exit 1; }
echo "RESULT: PASS"
exit 0

//--- tb_pwm_cmd_top.sv
`timescale 1ns/1ps
`include "pwm_cmd_defines.svh"
`default_nettype none

module tb_pwm_cmd_top;
    import pwm_cmd_pkg::*;

    localparam int          NROWS     = 10;
    localparam int          STB_TO_WE = 7;  // cycles from sampled stb to cmd_we
    localparam logic [15:0] REG_BASE  = `PWM_CMD_REG_BASE;
    localparam logic [15:0] CLR_ADDR  = `PWM_CMD_CLR_ADDR;
    localparam int          PRESC     = 2;
    localparam int          PER       = 9;
    localparam int          CMPV      = 4;

    logic        rst;   // clock
    logic        clk;   // async active high reset
    logic [7:0]  ad;
    logic        stb;
    wire  [15:0] cmd_addr;
    wire  [31:0] cmd_data;
    wire  [1:0]  cmd_we;
    wire         pwm_out;
    wire         pwm_wrap;

    int          cyc = 0;
    int          errors = 0;
    int          tests = 0;
    int          we_cyc_q [$];
    logic [1:0]  we_val_q [$];
    logic [15:0] we_addr_q [$];
    logic [31:0] we_data_q [$];

    logic [15:0] row_addr [NROWS];
    logic [31:0] row_data [NROWS];
    logic [1:0]  row_we   [NROWS];  // expected strobe or 0 for none
    logic        row_mid  [NROWS];  // extra stb on data byte 1
    int          row_gap  [NROWS];  // cycles to the next frame start
    int          row_k    [NROWS];

    pwm_cmd_top u_pwm_cmd_top (
        .rst      (rst),
        .clk      (clk),
        .ad       (ad),
        .stb      (stb),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_we   (cmd_we),
        .pwm_out  (pwm_out),
        .pwm_wrap (pwm_wrap)
    );

    initial begin
        rst = 1'b0;
        forever #20 rst = ~rst;
    end

    // strobe log where cyc counts the rising edges so far
    always @(negedge rst) begin
        cyc = cyc + 1;
        if (cmd_we != 2'b00) begin
            we_cyc_q.push_back(cyc);
            we_val_q.push_back(cmd_we);
            we_addr_q.push_back(cmd_addr);
            we_data_q.push_back(cmd_data);
        end
    end

    function automatic logic [1:0] expect_we(input logic [15:0] a);
        logic [1:0] w;
        w = 2'b00;
        if (((a ^ `PWM_CMD_REG_BASE) & `PWM_CMD_REG_MASK) == 16'h0000) begin
            w[WIN_REG] = 1'b1;
        end
        if (((a ^ `PWM_CMD_CLR_ADDR) & `PWM_CMD_CLR_MASK) == 16'h0000) begin
            w[WIN_CLR] = 1'b1;
        end
        return w;
    endfunction

    function automatic int find_strobe(input int at_cyc);
        foreach (we_cyc_q[j]) begin
            if (we_cyc_q[j] == at_cyc) begin
                return j;
            end
        end
        return -1;
    endfunction

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s FAILED, %0d errors", name, errors - err0);
        end
    endtask

    task automatic release_reset();
        repeat (2) @(posedge rst);
        clk <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge rst);
            stb <= 1'b0;
        end
    endtask

    // six bytes on consecutive edges with k the edge that samples stb
    task automatic send_frame(input logic [15:0] addr, input logic [31:0] data,
                              input logic mid_stb, output int k);
        logic [7:0] fb [0:5];
        int         b;
        fb[0] = addr[7:0];
        fb[1] = addr[15:8];
        fb[2] = data[7:0];
        fb[3] = data[15:8];
        fb[4] = data[23:16];
        fb[5] = data[31:24];
        k = 0;
        for (b = 0; b < `PWM_CMD_FRAME_BYTES; b++) begin
            @(posedge rst);
            if (b == 0) begin
                k = cyc + 2;  // DUT samples stb one edge after this one
            end
            ad  <= fb[b];
            stb <= (b == 0) || (mid_stb && b == 3);
        end
    endtask

    task automatic wait_strobes(input int count, input int limit, output bit ok);
        int n;
        n = 0;
        while (we_cyc_q.size() < count && n < limit) begin
            @(posedge rst);
            n++;
        end
        ok = (we_cyc_q.size() >= count);
    endtask

    task automatic set_row(input int i, input logic [15:0] addr, input logic [1:0] we,
                           input logic mid, input int gap);
        row_addr[i] = addr;
        row_data[i] = $urandom;
        row_we[i]   = we;
        row_mid[i]  = mid;
        row_gap[i]  = gap;
    endtask

    task automatic fill_table();
        logic [31:0] rnd;
        logic [15:0] addr;
        int          i;
        set_row(0, {REG_BASE[15:3], 3'd1}, 2'b01, 1'b0, 10);
        set_row(1, {REG_BASE[15:3], 3'd5}, 2'b01, 1'b0, 6);  // back to back
        set_row(2, {REG_BASE[15:3], 3'd7}, 2'b01, 1'b1, 6);
        set_row(3, CLR_ADDR, 2'b10, 1'b0, 12);
        set_row(4, 16'h0848, 2'b00, 1'b0, 12);               // one past the window
        set_row(5, 16'h08fe, 2'b00, 1'b0, 12);
        for (i = 6; i < NROWS; i++) begin
            rnd  = $urandom;
            addr = (i < 8) ? {8'h08, rnd[7:0]} : rnd[15:0];
            set_row(i, addr, expect_we(addr), (i == 9), 12);
        end
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] data,
                             input string name);
        int  n0;
        int  k;
        int  err0;
        bit  ok;
        err0 = errors;
        n0   = we_cyc_q.size();
        send_frame(addr, data, 1'b0, k);
        wait_strobes(n0 + 1, 20, ok);
        if (!ok) begin
            $display("%s: write strobe never arrived", name);
            errors++;
        end else begin
            if (we_cyc_q[n0] != k + STB_TO_WE) begin
                $display("Fail cmd_we cycle: got %h expected %h", we_cyc_q[n0],
                         k + STB_TO_WE);
                errors++;
            end
            if (we_val_q[n0] != expect_we(addr)) begin
                $display("Fail cmd_we: got %h expected %h", we_val_q[n0], expect_we(addr));
                errors++;
            end
            if (we_addr_q[n0] != addr) begin
                $display("Fail cmd_addr: got %h expected %h", we_addr_q[n0], addr);
                errors++;
            end
            if (we_data_q[n0] != data) begin
                $display("Fail cmd_data: got %h expected %h", we_data_q[n0], data);
                errors++;
            end
        end
        report_test(name, err0);
    endtask

    task automatic wait_wrap(input int limit, output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge rst);
            n++;
            seen = pwm_wrap;
        end
    endtask

    task automatic measure_period(input logic inv, input string name);
        int n;
        int high;
        int exp_gap;
        int exp_high;
        int err0;
        bit seen;
        err0     = errors;
        exp_gap  = (PRESC + 1) * (PER + 1);
        exp_high = (PRESC + 1) * ((CMPV < PER + 1) ? CMPV : PER + 1);
        if (inv) begin
            exp_high = exp_gap - exp_high;
        end
        wait_wrap(4 * exp_gap, seen);  // first period may straddle the write
        if (seen) begin
            wait_wrap(4 * exp_gap, seen);
        end
        if (!seen) begin
            $display("%s: pwm_wrap never pulsed", name);
            errors++;
        end else begin
            n    = 0;
            high = 0;
            do begin
                if (pwm_out) begin
                    high++;
                end
                n++;
                @(negedge rst);
            end while (!pwm_wrap && n < 2 * exp_gap);
            if (n != exp_gap) begin
                $display("Fail pwm_wrap gap: got %h expected %h", n, exp_gap);
                errors++;
            end
            if (high != exp_high) begin
                $display("Fail pwm_out high cycles: got %h expected %h", high, exp_high);
                errors++;
            end
        end
        report_test(name, err0);
    endtask

    task automatic check_idle(input logic exp_out, input int ncyc, input string name);
        int n;
        int err0;
        bit bad_wrap;
        bit bad_out;
        err0     = errors;
        bad_wrap = 1'b0;
        bad_out  = 1'b0;
        repeat (2) @(negedge rst);  // register update and then core output
        for (n = 0; n < ncyc; n++) begin
            if (pwm_wrap && !bad_wrap) begin
                $display("Fail pwm_wrap: got %h expected %h", pwm_wrap, 1'b0);
                errors++;
                bad_wrap = 1'b1;
            end
            if (pwm_out != exp_out && !bad_out) begin
                $display("Fail pwm_out: got %h expected %h", pwm_out, exp_out);
                errors++;
                bad_out = 1'b1;
            end
            @(negedge rst);
        end
        report_test(name, err0);
    endtask

    initial begin
        int          i;
        int          j;
        int          err0;
        int          n_exp;
        bit          ok;
        logic [31:0] rnd;
        void'($urandom(32'hca812bda));
        clk = 1'b1;
        ad  = 8'h00;
        stb = 1'b0;
        fill_table();
        release_reset();
        idle(2);

        n_exp = 0;
        for (i = 0; i < NROWS; i++) begin
            send_frame(row_addr[i], row_data[i], row_mid[i], row_k[i]);
            idle(row_gap[i] - `PWM_CMD_FRAME_BYTES);
            if (row_we[i] != 2'b00) begin
                n_exp++;
            end
        end
        wait_strobes(n_exp, 40, ok);
        if (!ok) begin
            $display("timed out waiting for the table write strobes");
            errors++;
        end
        idle(12);  // quiet window for frames that must not hit

        for (i = 0; i < NROWS; i++) begin
            err0 = errors;
            j    = find_strobe(row_k[i] + STB_TO_WE);
            if (row_we[i] == 2'b00) begin
                if (j >= 0) begin
                    $display("Fail cmd_we row %0d: got %h expected %h", i, we_val_q[j],
                             row_we[i]);
                    errors++;
                end
            end else if (j < 0) begin
                $display("row %0d: no write strobe %0d cycles after stb", i, STB_TO_WE);
                errors++;
            end else begin
                if (we_val_q[j] != row_we[i]) begin
                    $display("Fail cmd_we row %0d: got %h expected %h", i, we_val_q[j],
                             row_we[i]);
                    errors++;
                end
                if (we_addr_q[j] != row_addr[i]) begin
                    $display("Fail cmd_addr row %0d: got %h expected %h", i, we_addr_q[j],
                             row_addr[i]);
                    errors++;
                end
                if (we_data_q[j] != row_data[i]) begin
                    $display("Fail cmd_data row %0d: got %h expected %h", i, we_data_q[j],
                             row_data[i]);
                    errors++;
                end
            end
            report_test($sformatf("row %0d addr %h", i, row_addr[i]), err0);
        end
        err0 = errors;
        if (we_cyc_q.size() != n_exp) begin
            $display("saw %0d write strobes for %0d hitting frames", we_cyc_q.size(), n_exp);
            errors++;
        end
        report_test("strobe count", err0);

        // pwm duty, disable and clear
        rnd = $urandom;
        reg_write(CLR_ADDR, rnd, "clear before pwm");
        reg_write({REG_BASE[15:3], `PWM_OFS_PERIOD}, {16'h0000, 16'(PER)}, "period");
        reg_write({REG_BASE[15:3], `PWM_OFS_CMP}, {16'h0000, 16'(CMPV)}, "compare");
        reg_write({REG_BASE[15:3], `PWM_OFS_CTRL}, {16'h0000, 8'(PRESC), 8'h01}, "enable");
        measure_period(1'b0, "duty");
        reg_write({REG_BASE[15:3], `PWM_OFS_CTRL}, {16'h0000, 8'(PRESC), 8'h03}, "invert");
        measure_period(1'b1, "duty inverted");
        reg_write({REG_BASE[15:3], `PWM_OFS_CTRL}, {16'h0000, 8'(PRESC), 8'h02}, "disable");
        check_idle(1'b1, 4 * (PER + 1) * (PRESC + 1), "disabled output");
        reg_write({REG_BASE[15:3], `PWM_OFS_CTRL}, {16'h0000, 8'(PRESC), 8'h03}, "re-enable");
        measure_period(1'b1, "duty after re-enable");
        rnd = $urandom;
        reg_write(CLR_ADDR, rnd, "clear");
        check_idle(1'b0, 4 * (PER + 1) * (PRESC + 1), "cleared output");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
